// File: oam_dma.sv
`timescale 1ns/1ps

module oam_dma (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cpu_clk_en,
    input  logic                dma_start,
    input  ppu_pkg::byte_t      dma_page,
    input  logic                cpu_cyc_par,
    input  ppu_pkg::byte_t      cpu_rd_data,
    output logic                cpu_sus,
    output ppu_pkg::cpu_addr_t  cpu_addr,
    output logic                cpu_re,
    output logic                dma_we,
    output ppu_pkg::byte_t      dma_addr,
    output ppu_pkg::byte_t      dma_data
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_DUMMY1,
        S_DUMMY2,
        S_READ,
        S_WRITE
    } dma_state_t;

    dma_state_t     state;
    dma_state_t     state_nxt;
    ppu_pkg::byte_t count;
    logic           cnt_clr;
    logic           cnt_inc;
    logic           last;

    assign last = (count == 8'hff);

    // source is page:count, destination is oam[count]
    assign cpu_addr = {dma_page, count};
    assign dma_addr = count;
    // memory answers one enabled cycle after cpu_re, i.e. in the write state
    assign dma_data = cpu_rd_data;

    always_comb begin
        state_nxt = state;
        cpu_sus   = 1'b0;
        cpu_re    = 1'b0;
        dma_we    = 1'b0;
        cnt_clr   = 1'b0;
        cnt_inc   = 1'b0;
        case (state)
            S_IDLE: begin
                // suspend already in the cycle of the OAMDMA write
                cpu_sus = dma_start;
                if (dma_start) begin
                    state_nxt = S_DUMMY1;
                end
            end
            S_DUMMY1: begin
                cpu_sus   = 1'b1;
                cnt_clr   = 1'b1;
                // odd cpu cycle costs one extra alignment cycle
                state_nxt = cpu_cyc_par ? S_DUMMY2 : S_READ;
            end
            S_DUMMY2: begin
                cpu_sus   = 1'b1;
                state_nxt = S_READ;
            end
            S_READ: begin
                cpu_sus   = 1'b1;
                cpu_re    = 1'b1;
                state_nxt = S_WRITE;
            end
            S_WRITE: begin
                dma_we = 1'b1;
                // cpu is released during the final write
                cpu_sus = !last;
                if (last) begin
                    state_nxt = S_IDLE;
                end else begin
                    cnt_inc   = 1'b1;
                    state_nxt = S_READ;
                end
            end
            default: begin
                state_nxt = S_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
            count <= 8'h00;
        end else if (cpu_clk_en) begin
            state <= state_nxt;
            if (cnt_clr) begin
                count <= 8'h00;
            end else if (cnt_inc) begin
                count <= count + 8'h01;
            end
        end
    end

    // the cpu only comes back together with the final oam write
    a_release_at_end: assert property (
        @(posedge clk) disable iff (!rst_n)
        $fell(cpu_sus) |-> (state == S_WRITE) && last
    ) else $error("oam_dma: cpu_sus dropped before the last oam write");

endmodule

// File: ppu_async_ram.sv
`timescale 1ns/1ps

module ppu_async_ram #(
    parameter int ADDR_W = 8
) (
    input logic   clk,
    ppu_mem_if.mem port
);

    localparam int DEPTH = 1 << ADDR_W;

    ppu_pkg::byte_t mem [0:DEPTH-1];

    // read path has no register
    assign port.rd_data = mem[port.addr];

    always_ff @(posedge clk) begin
        if (port.we) begin
            mem[port.addr] <= port.wr_data;
        end
    end

    // the register block never reads and writes one ram on the same edge
    a_no_rd_wr_overlap: assert property (
        @(posedge clk) !(port.we && port.re)
    ) else $error("ppu_async_ram: we and re high together");

endmodule

// File: ppu_cpu_port.f
ppu_pkg.sv
ppu_mem_if.sv
ppu_async_ram.sv
oam_dma.sv
ppu_cpu_regs.sv
ppu_cpu_port.sv
tb_ppu_cpu_port.sv

// File: ppu_cpu_port.sv
`timescale 1ns/1ps

module ppu_cpu_port #(
    parameter int OAM_AW  = ppu_pkg::OAM_AW,
    parameter int VRAM_AW = ppu_pkg::VRAM_AW,
    parameter int PAL_AW  = ppu_pkg::PAL_AW
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cpu_clk_en,
    input  logic               ppu_clk_en,

    input  ppu_pkg::reg_t      reg_sel,
    input  logic               reg_en,
    input  logic               reg_rw,
    input  ppu_pkg::byte_t     reg_data_in,
    output ppu_pkg::byte_t     reg_data_out,

    input  logic               cpu_cyc_par,
    output logic               cpu_sus,

    // external cpu memory, data one enabled cycle after cpu_re
    output ppu_pkg::cpu_addr_t cpu_addr,
    output logic               cpu_re,
    input  ppu_pkg::byte_t     cpu_rd_data,

    input  logic               sp_over_set,
    input  logic               sp_over_clr,
    input  logic               sp_zero_set,
    input  logic               sp_zero_clr,
    input  logic               vblank_set,
    input  logic               vblank_clr,

    output ppu_pkg::byte_t     ppuctrl,
    output ppu_pkg::byte_t     ppumask,
    output ppu_pkg::byte_t     scroll_x,
    output ppu_pkg::byte_t     scroll_y
);

    logic           dma_start;
    ppu_pkg::byte_t dma_page;
    logic           dma_we;
    ppu_pkg::byte_t dma_addr;
    ppu_pkg::byte_t dma_data;

    ppu_mem_if #(.ADDR_W(OAM_AW))  oam_bus ();
    ppu_mem_if #(.ADDR_W(VRAM_AW)) vram_bus ();
    ppu_mem_if #(.ADDR_W(PAL_AW))  pal_bus ();

    ppu_cpu_regs #(
        .VRAM_AW (VRAM_AW),
        .PAL_AW  (PAL_AW)
    ) u_regs (
        .clk          (clk),
        .rst_n        (rst_n),
        .cpu_clk_en   (cpu_clk_en),
        .ppu_clk_en   (ppu_clk_en),
        .reg_sel      (reg_sel),
        .reg_en       (reg_en),
        .reg_rw       (reg_rw),
        .reg_data_in  (reg_data_in),
        .reg_data_out (reg_data_out),
        .sp_over_set  (sp_over_set),
        .sp_over_clr  (sp_over_clr),
        .sp_zero_set  (sp_zero_set),
        .sp_zero_clr  (sp_zero_clr),
        .vblank_set   (vblank_set),
        .vblank_clr   (vblank_clr),
        .ppuctrl      (ppuctrl),
        .ppumask      (ppumask),
        .scroll_x     (scroll_x),
        .scroll_y     (scroll_y),
        .dma_start    (dma_start),
        .dma_page     (dma_page),
        .dma_we       (dma_we),
        .dma_addr     (dma_addr),
        .dma_data     (dma_data),
        .cpu_sus      (cpu_sus),
        .oam_bus      (oam_bus.ctrl),
        .vram_bus     (vram_bus.ctrl),
        .pal_bus      (pal_bus.ctrl)
    );

    oam_dma u_dma (
        .clk         (clk),
        .rst_n       (rst_n),
        .cpu_clk_en  (cpu_clk_en),
        .dma_start   (dma_start),
        .dma_page    (dma_page),
        .cpu_cyc_par (cpu_cyc_par),
        .cpu_rd_data (cpu_rd_data),
        .cpu_sus     (cpu_sus),
        .cpu_addr    (cpu_addr),
        .cpu_re      (cpu_re),
        .dma_we      (dma_we),
        .dma_addr    (dma_addr),
        .dma_data    (dma_data)
    );

    ppu_async_ram #(.ADDR_W(OAM_AW)) u_oam (
        .clk  (clk),
        .port (oam_bus.mem)
    );

    ppu_async_ram #(.ADDR_W(VRAM_AW)) u_vram (
        .clk  (clk),
        .port (vram_bus.mem)
    );

    ppu_async_ram #(.ADDR_W(PAL_AW)) u_pal (
        .clk  (clk),
        .port (pal_bus.mem)
    );

endmodule

// File: ppu_cpu_regs.sv
`timescale 1ns/1ps

module ppu_cpu_regs #(
    parameter int VRAM_AW = ppu_pkg::VRAM_AW,
    parameter int PAL_AW  = ppu_pkg::PAL_AW
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            cpu_clk_en,
    input  logic            ppu_clk_en,

    input  ppu_pkg::reg_t   reg_sel,
    input  logic            reg_en,
    input  logic            reg_rw,
    input  ppu_pkg::byte_t  reg_data_in,
    output ppu_pkg::byte_t  reg_data_out,

    input  logic            sp_over_set,
    input  logic            sp_over_clr,
    input  logic            sp_zero_set,
    input  logic            sp_zero_clr,
    input  logic            vblank_set,
    input  logic            vblank_clr,

    output ppu_pkg::byte_t  ppuctrl,
    output ppu_pkg::byte_t  ppumask,
    output ppu_pkg::byte_t  scroll_x,
    output ppu_pkg::byte_t  scroll_y,

    output logic            dma_start,
    output ppu_pkg::byte_t  dma_page,
    input  logic            dma_we,
    input  ppu_pkg::byte_t  dma_addr,
    input  ppu_pkg::byte_t  dma_data,
    input  logic            cpu_sus,

    ppu_mem_if.ctrl         oam_bus,
    ppu_mem_if.ctrl         vram_bus,
    ppu_mem_if.ctrl         pal_bus
);

    typedef enum logic {
        WR_FIRST,
        WR_SECOND
    } wr_tog_t;

    wr_tog_t            scroll_tog;
    wr_tog_t            addr_tog;
    ppu_pkg::byte_t     oam_addr;
    ppu_pkg::ppu_addr_t ppu_addr;
    ppu_pkg::ppu_addr_t addr_step;
    ppu_pkg::byte_t     last_wr;
    ppu_pkg::byte_t     status;
    // {vblank, sprite 0 hit, sprite overflow}
    logic [2:0]         flags;
    logic [1:0]         vbl_cnt;

    logic acc;
    logic wr;
    logic rd;
    logic status_rd;
    logic oam_wr;
    logic oam_rd;
    logic data_rd;
    logic data_wr;
    logic in_vram;
    logic in_pal;

    // bus strobes, valid only on enabled cpu edges
    assign acc       = reg_en && cpu_clk_en;
    assign wr        = acc && reg_rw;
    assign rd        = acc && !reg_rw;
    assign status_rd = rd && (reg_sel == ppu_pkg::PPUSTATUS);
    assign oam_wr    = wr && (reg_sel == ppu_pkg::OAMDATA);
    assign oam_rd    = rd && (reg_sel == ppu_pkg::OAMDATA);
    assign data_wr   = wr && (reg_sel == ppu_pkg::PPUDATA);
    assign data_rd   = rd && (reg_sel == ppu_pkg::PPUDATA);

    // not qualified by cpu_clk_en so the suspend shows up early
    assign dma_start = reg_en && reg_rw && (reg_sel == ppu_pkg::OAMDMA);

    assign addr_step = ppuctrl[2] ? 16'd32 : 16'd1;

    // nametables 0/1 and their 0x3000 mirror; chr and nametables 2/3 absent
    assign in_vram = ((ppu_addr >= 16'h2000) && (ppu_addr <= 16'h27ff)) ||
                     ((ppu_addr >= 16'h3000) && (ppu_addr <= 16'h37ff));
    assign in_pal  = (ppu_addr >= 16'h3f00) && (ppu_addr <= 16'h3fff);

    assign status = {flags, last_wr[4:0]};

    // oam port, dma write wins
    assign oam_bus.addr    = dma_we ? dma_addr : oam_addr;
    assign oam_bus.wr_data = dma_we ? dma_data : reg_data_in;
    assign oam_bus.we      = cpu_clk_en && (dma_we || oam_wr);
    assign oam_bus.re      = oam_rd && !dma_we;

    assign vram_bus.addr    = ppu_addr[VRAM_AW-1:0];
    assign vram_bus.wr_data = reg_data_in;
    assign vram_bus.we      = data_wr && in_vram;
    assign vram_bus.re      = data_rd && !in_pal;

    assign pal_bus.addr    = ppu_addr[PAL_AW-1:0];
    assign pal_bus.wr_data = reg_data_in;
    assign pal_bus.we      = data_wr && in_pal;
    assign pal_bus.re      = data_rd && in_pal;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ppuctrl      <= 8'h00;
            ppumask      <= 8'h00;
            scroll_x     <= 8'h00;
            scroll_y     <= 8'h00;
            oam_addr     <= 8'h00;
            ppu_addr     <= 16'h0000;
            dma_page     <= 8'h00;
            last_wr      <= 8'h00;
            reg_data_out <= 8'h00;
            scroll_tog   <= WR_FIRST;
            addr_tog     <= WR_FIRST;
        end else if (wr) begin
            last_wr <= reg_data_in;
            case (reg_sel)
                ppu_pkg::PPUCTRL: ppuctrl <= reg_data_in;
                ppu_pkg::PPUMASK: ppumask <= reg_data_in;
                ppu_pkg::OAMADDR: oam_addr <= reg_data_in;
                ppu_pkg::OAMDATA: oam_addr <= oam_addr + 8'h01;
                ppu_pkg::PPUSCROLL: begin
                    if (scroll_tog == WR_FIRST) begin
                        scroll_x   <= reg_data_in;
                        scroll_tog <= WR_SECOND;
                    end else begin
                        scroll_y   <= reg_data_in;
                        scroll_tog <= WR_FIRST;
                    end
                end
                ppu_pkg::PPUADDR: begin
                    // high byte first
                    if (addr_tog == WR_FIRST) begin
                        ppu_addr[15:8] <= reg_data_in;
                        addr_tog       <= WR_SECOND;
                    end else begin
                        ppu_addr[7:0] <= reg_data_in;
                        addr_tog      <= WR_FIRST;
                    end
                end
                ppu_pkg::PPUDATA: ppu_addr <= ppu_addr + addr_step;
                ppu_pkg::OAMDMA: dma_page <= reg_data_in;
                default: begin
                end
            endcase
        end else if (rd) begin
            case (reg_sel)
                ppu_pkg::PPUSTATUS: begin
                    reg_data_out <= status;
                    scroll_x     <= 8'h00;
                    scroll_y     <= 8'h00;
                    ppu_addr     <= 16'h0000;
                end
                // no increment on oam reads
                ppu_pkg::OAMDATA: reg_data_out <= oam_bus.rd_data;
                ppu_pkg::PPUDATA: begin
                    reg_data_out <= in_pal ? pal_bus.rd_data : vram_bus.rd_data;
                    ppu_addr     <= ppu_addr + addr_step;
                end
                default: begin
                end
            endcase
        end
    end

    // flags follow the renderer pulses, clear beats set
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flags   <= 3'b000;
            vbl_cnt <= 2'd0;
        end else begin
            // vblank drops on the second ppu edge after a status read
            if (status_rd) begin
                vbl_cnt <= 2'd2;
            end else if (ppu_clk_en && (vbl_cnt != 2'd0)) begin
                vbl_cnt <= vbl_cnt - 2'd1;
            end
            if (ppu_clk_en) begin
                if (sp_over_set) flags[0] <= 1'b1;
                if (sp_over_clr) flags[0] <= 1'b0;
                if (sp_zero_set) flags[1] <= 1'b1;
                if (sp_zero_clr) flags[1] <= 1'b0;
                if (vblank_set) flags[2] <= 1'b1;
                if (vblank_clr || (vbl_cnt == 2'd1)) flags[2] <= 1'b0;
            end
        end
    end

    // cpu stays off the bus while dma owns it, except for the OAMDMA write itself
    a_no_access_when_sus: assert property (
        @(posedge clk) disable iff (!rst_n)
        cpu_clk_en && cpu_sus && !dma_start |-> !reg_en
    ) else $error("ppu_cpu_regs: register access during dma suspend");

endmodule

// File: ppu_mem_if.sv
`timescale 1ns/1ps

interface ppu_mem_if #(
    parameter int ADDR_W = 8
);

    logic [ADDR_W-1:0] addr;
    logic              we;
    logic              re;
    ppu_pkg::byte_t    wr_data;
    // combinational, valid in the same cycle as addr
    ppu_pkg::byte_t    rd_data;

    // register block side
    modport ctrl (
        output addr,
        output we,
        output re,
        output wr_data,
        input  rd_data
    );

    // ram side
    modport mem (
        input  addr,
        input  we,
        input  re,
        input  wr_data,
        output rd_data
    );

endinterface

// File: ppu_pkg.sv
package ppu_pkg;

    // cpu-visible register select, offsets 0..7 of the ppu window plus oamdma
    typedef enum logic [3:0] {
        PPUCTRL   = 4'd0,
        PPUMASK   = 4'd1,
        PPUSTATUS = 4'd2,
        OAMADDR   = 4'd3,
        OAMDATA   = 4'd4,
        PPUSCROLL = 4'd5,
        PPUADDR   = 4'd6,
        PPUDATA   = 4'd7,
        OAMDMA    = 4'd8
    } reg_t;

    // one byte on any data bus
    typedef logic [7:0] byte_t;

    // full ppu address as built by two PPUADDR writes
    typedef logic [15:0] ppu_addr_t;

    // cpu address used by the sprite dma reads
    typedef logic [15:0] cpu_addr_t;

    // oam holds 64 sprites of 4 bytes
    localparam int OAM_AW = 8;

    // two physical nametables of 1 KiB each
    localparam int VRAM_AW = 11;

    // 32 palette entries
    localparam int PAL_AW = 5;

endpackage

// File: tb_ppu_cpu_port.sv
`timescale 1ns/1ps

module tb_ppu_cpu_port;

    localparam logic [31:0] LCG_SEED = 32'h8284_b48f;
    localparam int EDGE_TIMEOUT = 10;
    localparam int DMA_TIMEOUT  = 4000;

    logic               clk;
    logic               rst_n;
    logic               cpu_clk_en;
    logic               ppu_clk_en;
    ppu_pkg::reg_t      reg_sel;
    logic               reg_en;
    logic               reg_rw;
    ppu_pkg::byte_t     reg_data_in;
    ppu_pkg::byte_t     reg_data_out;
    logic               cpu_cyc_par;
    logic               cpu_sus;
    ppu_pkg::cpu_addr_t cpu_addr;
    logic               cpu_re;
    ppu_pkg::byte_t     cpu_rd_data;
    logic               sp_over_set;
    logic               sp_over_clr;
    logic               sp_zero_set;
    logic               sp_zero_clr;
    logic               vblank_set;
    logic               vblank_clr;
    ppu_pkg::byte_t     ppuctrl;
    ppu_pkg::byte_t     ppumask;
    ppu_pkg::byte_t     scroll_x;
    ppu_pkg::byte_t     scroll_y;

    logic [1:0]     en_phase;
    logic [31:0]    lcg_state;
    ppu_pkg::byte_t exp_page;
    int             fail_count;
    int             timeout_count;
    int             run_sus;
    int             run_re;
    int             last_sus;
    int             last_re;
    int             dma_done_cnt;
    logic           sus_prev;

    ppu_cpu_port UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .cpu_clk_en   (cpu_clk_en),
        .ppu_clk_en   (ppu_clk_en),
        .reg_sel      (reg_sel),
        .reg_en       (reg_en),
        .reg_rw       (reg_rw),
        .reg_data_in  (reg_data_in),
        .reg_data_out (reg_data_out),
        .cpu_cyc_par  (cpu_cyc_par),
        .cpu_sus      (cpu_sus),
        .cpu_addr     (cpu_addr),
        .cpu_re       (cpu_re),
        .cpu_rd_data  (cpu_rd_data),
        .sp_over_set  (sp_over_set),
        .sp_over_clr  (sp_over_clr),
        .sp_zero_set  (sp_zero_set),
        .sp_zero_clr  (sp_zero_clr),
        .vblank_set   (vblank_set),
        .vblank_clr   (vblank_clr),
        .ppuctrl      (ppuctrl),
        .ppumask      (ppumask),
        .scroll_x     (scroll_x),
        .scroll_y     (scroll_y)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // cpu runs at a third of clk
    always @(posedge clk) begin
        en_phase   <= (en_phase == 2'd2) ? 2'd0 : en_phase + 2'd1;
        cpu_clk_en <= (en_phase == 2'd2);
    end

    function automatic ppu_pkg::byte_t mem_pattern(input ppu_pkg::cpu_addr_t a);
        return a[7:0] ^ a[15:8] ^ 8'h5a;
    endfunction

    // cpu work memory, data one enabled cycle after cpu_re
    always @(posedge clk) begin
        if (cpu_clk_en && cpu_re) begin
            cpu_rd_data <= mem_pattern(cpu_addr);
        end
    end

    // suspend length and read count per dma run
    always @(posedge clk) begin
        if (rst_n && cpu_clk_en) begin
            if (cpu_sus) run_sus++;
            if (cpu_re) run_re++;
            if (sus_prev && !cpu_sus) begin
                last_sus = run_sus;
                last_re  = run_re;
                run_sus  = 0;
                run_re   = 0;
                dma_done_cnt++;
            end
            sus_prev = cpu_sus;
        end
    end

    a_re_inside_sus: assert property (
        @(posedge clk) disable iff (!rst_n) cpu_re |-> cpu_sus
    ) else begin
        fail_count++;
        $display("[FAIL] cpu_sus: got 0x%0h with cpu_re high, expected 0x1", cpu_sus);
    end

    a_dma_page: assert property (
        @(posedge clk) disable iff (!rst_n) cpu_re |-> (cpu_addr[15:8] == exp_page)
    ) else begin
        fail_count++;
        $display("[FAIL] cpu_addr: got 0x%0h, expected page 0x%0h", cpu_addr, exp_page);
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic rand_byte(output ppu_pkg::byte_t b);
        lcg_state = lcg_next(lcg_state);
        b = lcg_state[23:16];
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp) else begin
            fail_count++;
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    // returns on the next clk edge that the cpu side samples
    task automatic wait_cpu_edge();
        int n;
        n = 0;
        @(posedge clk);
        while (!cpu_clk_en && n < EDGE_TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (!cpu_clk_en) begin
            timeout_count++;
            $display("timeout while waiting for an enabled cpu cycle");
        end
    endtask

    task automatic reg_write(input ppu_pkg::reg_t sel, input ppu_pkg::byte_t data);
        wait_cpu_edge();
        reg_sel     <= sel;
        reg_rw      <= 1'b1;
        reg_data_in <= data;
        reg_en      <= 1'b1;
        wait_cpu_edge();
        reg_en <= 1'b0;
        reg_rw <= 1'b0;
        @(negedge clk);
    endtask

    task automatic reg_read(input ppu_pkg::reg_t sel, output ppu_pkg::byte_t data);
        wait_cpu_edge();
        reg_sel <= sel;
        reg_rw  <= 1'b0;
        reg_en  <= 1'b1;
        wait_cpu_edge();
        reg_en <= 1'b0;
        @(negedge clk);
        data = reg_data_out;
    endtask

    task automatic set_ppu_addr(input ppu_pkg::ppu_addr_t a);
        reg_write(ppu_pkg::PPUADDR, a[15:8]);
        reg_write(ppu_pkg::PPUADDR, a[7:0]);
    endtask

    // write n bytes through PPUDATA, read them back, spot check the last address
    task automatic data_block(input ppu_pkg::ppu_addr_t base, input int step, input int n);
        ppu_pkg::byte_t     wr_bytes [0:7];
        ppu_pkg::byte_t     rd;
        ppu_pkg::ppu_addr_t last_addr;
        reg_write(ppu_pkg::PPUCTRL, (step == 32) ? 8'h04 : 8'h00);
        set_ppu_addr(base);
        for (int i = 0; i < n; i++) begin
            rand_byte(wr_bytes[i]);
            reg_write(ppu_pkg::PPUDATA, wr_bytes[i]);
        end
        set_ppu_addr(base);
        for (int i = 0; i < n; i++) begin
            reg_read(ppu_pkg::PPUDATA, rd);
            check_val("reg_data_out", rd, wr_bytes[i]);
        end
        last_addr = base + ppu_pkg::ppu_addr_t'((n - 1) * step);
        set_ppu_addr(last_addr);
        reg_read(ppu_pkg::PPUDATA, rd);
        check_val("reg_data_out", rd, wr_bytes[n-1]);
    endtask

    task automatic pulse_flags(input logic [5:0] f);
        @(posedge clk);
        {sp_over_set, sp_over_clr, sp_zero_set, sp_zero_clr, vblank_set, vblank_clr} <= f;
        @(posedge clk);
        {sp_over_set, sp_over_clr, sp_zero_set, sp_zero_clr, vblank_set, vblank_clr} <= 6'b0;
    endtask

    task automatic run_dma(input logic par);
        ppu_pkg::byte_t page;
        ppu_pkg::byte_t rd;
        int             done_before;
        int             n;
        rand_byte(page);
        @(posedge clk);
        exp_page    <= page;
        cpu_cyc_par <= par;
        done_before = dma_done_cnt;
        reg_write(ppu_pkg::OAMDMA, page);
        n = 0;
        while (dma_done_cnt == done_before && n < DMA_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (dma_done_cnt == done_before) begin
            timeout_count++;
            $display("timeout while waiting for the sprite dma to release the cpu");
        end
        check_val("cpu_sus cycles", last_sus, par ? 514 : 513);
        check_val("cpu_re pulses", last_re, 256);
        for (int i = 0; i < 256; i++) begin
            reg_write(ppu_pkg::OAMADDR, ppu_pkg::byte_t'(i));
            reg_read(ppu_pkg::OAMDATA, rd);
            check_val("oam entry", rd, mem_pattern({page, ppu_pkg::byte_t'(i)}));
        end
    endtask

    initial begin
        ppu_pkg::byte_t b0;
        ppu_pkg::byte_t b1;
        ppu_pkg::byte_t rd;
        ppu_pkg::byte_t oam_bytes [0:3];
        clk_setup: begin
            rst_n       = 1'b0;
            en_phase    = 2'd0;
            cpu_clk_en  = 1'b0;
            ppu_clk_en  = 1'b0;
            reg_sel     = ppu_pkg::PPUCTRL;
            reg_en      = 1'b0;
            reg_rw      = 1'b0;
            reg_data_in = 8'h00;
            cpu_cyc_par = 1'b0;
            cpu_rd_data = 8'h00;
            {sp_over_set, sp_over_clr, sp_zero_set, sp_zero_clr, vblank_set, vblank_clr} = 6'b0;
        end
        lcg_state     = LCG_SEED;
        exp_page      = 8'h00;
        fail_count    = 0;
        timeout_count = 0;
        run_sus       = 0;
        run_re        = 0;
        last_sus      = 0;
        last_re       = 0;
        dma_done_cnt  = 0;
        sus_prev      = 1'b0;

        repeat (8) @(posedge clk);
        rst_n      <= 1'b1;
        ppu_clk_en <= 1'b1;
        @(negedge clk);

        // reset state and plain register writes
        check_val("ppuctrl", ppuctrl, 0);
        check_val("ppumask", ppumask, 0);
        check_val("scroll_x", scroll_x, 0);
        check_val("scroll_y", scroll_y, 0);
        check_val("cpu_sus", cpu_sus, 0);
        check_val("cpu_re", cpu_re, 0);
        rand_byte(b0);
        reg_write(ppu_pkg::PPUCTRL, b0);
        check_val("ppuctrl", ppuctrl, b0);
        rand_byte(b0);
        reg_write(ppu_pkg::PPUMASK, b0);
        check_val("ppumask", ppumask, b0);
        rand_byte(b0);
        rand_byte(b1);
        reg_write(ppu_pkg::PPUSCROLL, b0);
        reg_write(ppu_pkg::PPUSCROLL, b1);
        check_val("scroll_x", scroll_x, b0);
        check_val("scroll_y", scroll_y, b1);

        // vram with both steps, then palette
        data_block(16'h2123, 1, 8);
        data_block(16'h2400, 32, 6);
        data_block(16'h3f00, 1, 4);

        // 0x3000 mirror lands in nametable space
        reg_write(ppu_pkg::PPUCTRL, 8'h00);
        rand_byte(b0);
        set_ppu_addr(16'h3045);
        reg_write(ppu_pkg::PPUDATA, b0);
        set_ppu_addr(16'h2045);
        reg_read(ppu_pkg::PPUDATA, rd);
        check_val("reg_data_out", rd, b0);

        // chr writes are dropped
        rand_byte(b0);
        set_ppu_addr(16'h2010);
        reg_write(ppu_pkg::PPUDATA, b0);
        set_ppu_addr(16'h0010);
        reg_write(ppu_pkg::PPUDATA, ~b0);
        set_ppu_addr(16'h2010);
        reg_read(ppu_pkg::PPUDATA, rd);
        check_val("reg_data_out", rd, b0);

        // OAMDATA writes step the address, reads do not
        reg_write(ppu_pkg::OAMADDR, 8'h40);
        for (int i = 0; i < 4; i++) begin
            rand_byte(oam_bytes[i]);
            reg_write(ppu_pkg::OAMDATA, oam_bytes[i]);
        end
        for (int i = 0; i < 4; i++) begin
            reg_write(ppu_pkg::OAMADDR, 8'h40 + ppu_pkg::byte_t'(i));
            reg_read(ppu_pkg::OAMDATA, rd);
            check_val("reg_data_out", rd, oam_bytes[i]);
        end
        reg_write(ppu_pkg::OAMADDR, 8'h42);
        repeat (3) begin
            reg_read(ppu_pkg::OAMDATA, rd);
            check_val("reg_data_out", rd, oam_bytes[2]);
        end

        // status flags, sprite 0 set then set and clear together
        pulse_flags(6'b101010);
        pulse_flags(6'b001100);
        rand_byte(b0);
        rand_byte(b1);
        reg_write(ppu_pkg::PPUSCROLL, b0 | 8'h01);
        reg_write(ppu_pkg::PPUSCROLL, b1 | 8'h01);
        b1 = b1 | 8'h01;
        reg_read(ppu_pkg::PPUSTATUS, rd);
        check_val("reg_data_out", rd, {3'b101, b1[4:0]});
        check_val("scroll_x", scroll_x, 0);
        check_val("scroll_y", scroll_y, 0);
        reg_read(ppu_pkg::PPUSTATUS, rd);
        check_val("reg_data_out", rd, {3'b001, b1[4:0]});

        // sprite dma on an even and on an odd cpu cycle
        run_dma(1'b0);
        run_dma(1'b1);

        $display("error count: %0d check failures, %0d timeouts", fail_count, timeout_count);
        if (fail_count == 0 && timeout_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
